// ==== verilog.f ====
rename_cfg_pkg.sv
rename_bus_pkg.sv
map_table.sv
waw_filter.sv
src_bypass.sv
free_list.sv
rename_ctrl.sv
rename_unit.sv
rename_checker.sv
tb_rename_unit.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
TOP        = tb_rename_unit
RTL_TOP    = rename_unit
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_rename_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rename_unit;

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    typedef struct packed {
        areg_t rd;
        preg_t prd;
        preg_t old_prd;
    } rob_entry_t;

    logic clk;
    logic rst;
    logic stall;
    logic walk_start;
    logic walk_done;
    rename_slot_t rename_req [rename_width];
    rename_slot_t held [rename_width];
    rename_res_t rename_res [rename_width];
    commit_slot_t commit_grp [commit_width];
    preg_t free_prd [commit_width];
    walk_slot_t walk_grp [walk_width];

    // reference model
    preg_t spec_map [arch_regs];
    preg_t arch_map [arch_regs];
    preg_t free_q [$];
    rob_entry_t rob_q [$];
    logic walking;

    logic exp_stall;
    logic seen_stall;
    rename_res_t exp_res [rename_width];
    preg_t exp_free [commit_width];
    logic [rename_width-1:0] res_chk;
    logic [rename_width-1:0] prd_chk;
    logic [commit_width-1:0] free_chk;
    int errors;
    int timeouts;
    int seed;

    rename_unit DUT (
        .clk(clk), .rst(rst), .rename_req(rename_req), .rename_res(rename_res),
        .stall(stall), .commit_grp(commit_grp), .free_prd(free_prd),
        .walk_start(walk_start), .walk_done(walk_done), .walk_grp(walk_grp)
    );

    rename_checker u_checker (
        .clk(clk), .rst(rst), .stall(stall), .rename_res(rename_res),
        .free_prd(free_prd), .exp_stall(exp_stall), .exp_res(exp_res),
        .res_chk(res_chk), .prd_chk(prd_chk), .exp_free(exp_free),
        .free_chk(free_chk), .errors(errors)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic preg_t pool_at(int k);
        if (k < free_q.size())
            return free_q[k];
        return '0;
    endfunction

    function automatic int group_demand();
        int n;
        n = 0;
        for (int i = 0; i < rename_width; i++) begin
            if (rename_req[i].valid && rename_req[i].has_rd)
                n++;
        end
        return n;
    endfunction

    function automatic rename_res_t ref_rename(int s);
        rename_res_t r;
        int k;
        r.prs1 = spec_map[rename_req[s].rs1];
        r.prs2 = spec_map[rename_req[s].rs2];
        r.old_prd = spec_map[rename_req[s].rd];
        k = 0;
        // earlier destinations of the group shadow the table
        for (int j = 0; j < s; j++) begin
            if (rename_req[j].valid && rename_req[j].has_rd) begin
                if (rename_req[s].rs1 == rename_req[j].rd)
                    r.prs1 = pool_at(k);
                if (rename_req[s].rs2 == rename_req[j].rd)
                    r.prs2 = pool_at(k);
                if (rename_req[s].rd == rename_req[j].rd)
                    r.old_prd = pool_at(k);
                k++;
            end
        end
        r.prd = pool_at(k);
        return r;
    endfunction

    // an overwritten commit frees its own prd
    function automatic preg_t ref_free(int s);
        for (int j = s + 1; j < commit_width; j++) begin
            if (commit_grp[j].en && commit_grp[j].we && commit_grp[j].rd == commit_grp[s].rd)
                return commit_grp[s].prd;
        end
        return arch_map[commit_grp[s].rd];
    endfunction

    task automatic set_idle();
        walk_start = 1'b0;
        walk_done = 1'b0;
        for (int i = 0; i < rename_width; i++)
            rename_req[i] = '0;
        for (int i = 0; i < commit_width; i++)
            commit_grp[i] = '0;
        for (int i = 0; i < walk_width; i++)
            walk_grp[i] = '0;
    endtask

    task automatic set_slot(int i, int rd, int rs1, int rs2);
        rename_req[i].valid = 1'b1;
        rename_req[i].has_rd = (rd != 0);
        rename_req[i].rd = areg_t'(rd);
        rename_req[i].rs1 = areg_t'(rs1);
        rename_req[i].rs2 = areg_t'(rs2);
    endtask

    task automatic commit_oldest(int n);
        rob_entry_t e;
        for (int i = 0; i < commit_width; i++) begin
            if (i < n && rob_q.size() > 0) begin
                e = rob_q.pop_front();
                commit_grp[i] = '{en: 1'b1, we: 1'b1, rd: e.rd, prd: e.prd};
            end
        end
    endtask

    // slot 0 takes the youngest entry
    task automatic walk_youngest(int n);
        rob_entry_t e;
        for (int i = 0; i < walk_width; i++) begin
            if (i < n && rob_q.size() > 0) begin
                e = rob_q.pop_back();
                walk_grp[i] = '{en: 1'b1, we: 1'b1, rd: e.rd, prd: e.prd, old_prd: e.old_prd};
            end
        end
    endtask

    task automatic update_model();
        preg_t freed [commit_width];
        rob_entry_t e;
        for (int i = 0; i < commit_width; i++)
            freed[i] = ref_free(i);
        for (int i = 0; i < commit_width; i++) begin
            if (commit_grp[i].en && commit_grp[i].we)
                arch_map[commit_grp[i].rd] = commit_grp[i].prd;
        end
        if (!exp_stall) begin
            for (int i = 0; i < rename_width; i++) begin
                if (rename_req[i].valid && rename_req[i].has_rd) begin
                    spec_map[rename_req[i].rd] = exp_res[i].prd;
                    e.rd = rename_req[i].rd;
                    e.prd = exp_res[i].prd;
                    e.old_prd = exp_res[i].old_prd;
                    rob_q.push_back(e);
                    void'(free_q.pop_front());
                end
            end
        end
        if (walking) begin
            for (int i = 0; i < walk_width; i++) begin
                if (walk_grp[i].en && walk_grp[i].we)
                    spec_map[walk_grp[i].rd] = walk_grp[i].old_prd;
            end
            for (int i = 0; i < walk_width; i++) begin
                if (walk_grp[i].en && walk_grp[i].we)
                    free_q.push_front(walk_grp[i].prd);
            end
        end
        for (int i = 0; i < commit_width; i++) begin
            if (commit_grp[i].en && commit_grp[i].we)
                free_q.push_back(freed[i]);
        end
        if (walk_start)
            walking = 1'b1;
        else if (walk_done)
            walking = 1'b0;
    endtask

    // inputs are already driven for this cycle
    task automatic run_cycle();
        exp_stall = walking || (free_q.size() < group_demand());
        for (int i = 0; i < rename_width; i++) begin
            exp_res[i] = ref_rename(i);
            res_chk[i] = rename_req[i].valid && !exp_stall;
            prd_chk[i] = res_chk[i] && rename_req[i].has_rd;
        end
        for (int i = 0; i < commit_width; i++) begin
            exp_free[i] = ref_free(i);
            free_chk[i] = commit_grp[i].en && commit_grp[i].we;
        end
        #1;
        seen_stall = stall;
        @(posedge clk);
        @(negedge clk);
        update_model();
        set_idle();
    endtask

    task automatic run_all();
        int n;
        int dem;
        int stalled;
        logic hold;
        set_slot(0, 1, 2, 3);
        set_slot(1, 4, 1, 5);
        run_cycle();
        set_slot(0, 6, 1, 4);
        set_slot(1, 6, 6, 7);
        run_cycle();
        set_slot(0, 9, 6, 0);
        set_slot(1, 9, 9, 4);
        commit_oldest(2);
        run_cycle();
        // second commit group is the rd 6 pair, the third the rd 9 pair
        commit_oldest(2);
        run_cycle();
        commit_oldest(2);
        run_cycle();
        while (free_q.size() >= 2) begin
            set_slot(0, 1 + rand_below(31), rand_below(32), rand_below(32));
            set_slot(1, 1 + rand_below(31), rand_below(32), rand_below(32));
            run_cycle();
        end
        set_slot(0, 3, 9, 1);
        set_slot(1, 9, 3, 3);
        held = rename_req;
        n = 0;
        do begin
            rename_req = held;
            commit_oldest(1);
            run_cycle();
            n++;
        end while (seen_stall && n < 20);
        if (seen_stall) begin
            $display("timeout: the rename stage stayed stalled for %0d cycles", n);
            timeouts++;
            return;
        end
        while (rob_q.size() > 2) begin
            commit_oldest(2);
            run_cycle();
        end
        set_slot(0, 12, 3, 9);
        set_slot(1, 12, 12, 5);
        run_cycle();
        set_slot(0, 13, 12, 12);
        set_slot(1, 14, 13, 1);
        run_cycle();
        walk_start = 1'b1;
        run_cycle();
        n = 0;
        while (rob_q.size() > 0 && n < 8) begin
            walk_youngest(2);
            run_cycle();
            n++;
        end
        walk_done = 1'b1;
        run_cycle();
        set_slot(0, 14, 12, 13);
        set_slot(1, 12, 14, 9);
        run_cycle();
        hold = 1'b0;
        stalled = 0;
        for (int c = 0; c < 2000; c++) begin
            if (walking) begin
                if (rob_q.size() == 0 || rand_below(4) == 0)
                    walk_done = 1'b1;
                else
                    walk_youngest(1 + rand_below(2));
            end else if (hold) begin
                rename_req = held;
                commit_oldest(rand_below(3));
            end else if (rob_q.size() > 0 && rand_below(24) == 0) begin
                walk_start = 1'b1;
            end else begin
                for (int i = 0; i < rename_width; i++) begin
                    rename_req[i].valid = (rand_below(4) != 0);
                    rename_req[i].rd = areg_t'(rand_below(16));
                    rename_req[i].has_rd = (rand_below(4) != 0) && (rename_req[i].rd != 0);
                    rename_req[i].rs1 = areg_t'(rand_below(32));
                    rename_req[i].rs2 = areg_t'(rand_below(32));
                end
                held = rename_req;
                commit_oldest(rand_below(3));
            end
            dem = group_demand();
            run_cycle();
            hold = seen_stall && (dem > 0);
            stalled = hold ? stalled + 1 : 0;
            if (stalled >= 20) begin
                $display("timeout: the rename stage stayed stalled for %0d cycles", stalled);
                timeouts++;
                return;
            end
        end
    endtask

    initial begin
        seed = 81;
        timeouts = 0;
        walking = 1'b0;
        exp_stall = 1'b0;
        res_chk = '0;
        prd_chk = '0;
        free_chk = '0;
        rst = 1'b1;
        set_idle();
        for (int a = 0; a < arch_regs; a++) begin
            spec_map[a] = preg_t'(a);
            arch_map[a] = preg_t'(a);
        end
        for (int p = arch_regs; p < phys_regs; p++)
            free_q.push_back(preg_t'(p));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_all();
        repeat (2) run_cycle();
        $display("rename checks done: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_checker (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    stall,
    input  rename_bus_pkg::rename_res_t             rename_res [rename_cfg_pkg::rename_width],
    input  rename_bus_pkg::preg_t                   free_prd [rename_cfg_pkg::commit_width],
    input  logic                                    exp_stall,
    input  rename_bus_pkg::rename_res_t             exp_res [rename_cfg_pkg::rename_width],
    input  logic [rename_cfg_pkg::rename_width-1:0] res_chk,
    input  logic [rename_cfg_pkg::rename_width-1:0] prd_chk,
    input  rename_bus_pkg::preg_t                   exp_free [rename_cfg_pkg::commit_width],
    input  logic [rename_cfg_pkg::commit_width-1:0] free_chk,
    output int                                      errors
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    task automatic compare(string what, int slot, int got, int want);
        if (got != want) begin
            errors++;
            $display("ERROR at %0t: %s slot %0d got %0d, expected %0d",
                     $time, what, slot, got, want);
        end
    endtask

    // inputs change on the falling edge, so everything is settled here
    always @(posedge clk) begin
        if (rst) begin
            errors = 0;
        end else begin
            compare("stall", 0, int'(stall), int'(exp_stall));
            for (int i = 0; i < rename_width; i++) begin
                if (res_chk[i]) begin
                    compare("prs1", i, int'(rename_res[i].prs1), int'(exp_res[i].prs1));
                    compare("prs2", i, int'(rename_res[i].prs2), int'(exp_res[i].prs2));
                    compare("old_prd", i, int'(rename_res[i].old_prd), int'(exp_res[i].old_prd));
                end
                if (prd_chk[i])
                    compare("prd", i, int'(rename_res[i].prd), int'(exp_res[i].prd));
            end
            for (int i = 0; i < commit_width; i++) begin
                if (free_chk[i])
                    compare("free_prd", i, int'(free_prd[i]), int'(exp_free[i]));
            end
        end
    end

endmodule

`default_nettype wire

// ==== rename_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  rename_bus_pkg::rename_slot_t rename_req [rename_cfg_pkg::rename_width],
    output rename_bus_pkg::rename_res_t  rename_res [rename_cfg_pkg::rename_width],
    output logic                         stall,
    input  rename_bus_pkg::commit_slot_t commit_grp [rename_cfg_pkg::commit_width],
    output rename_bus_pkg::preg_t        free_prd [rename_cfg_pkg::commit_width],
    input  logic                         walk_start,
    input  logic                         walk_done,
    input  rename_bus_pkg::walk_slot_t   walk_grp [rename_cfg_pkg::walk_width]
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    areg_t spec_raddr [spec_reads];
    preg_t spec_rdata [spec_reads];
    preg_t table_rs1 [rename_width];
    preg_t table_rs2 [rename_width];
    preg_t table_rd [rename_width];
    logic [rename_width-1:0] spec_we;
    areg_t spec_waddr [rename_width];
    preg_t spec_wdata [rename_width];
    preg_t alloc_prd [rename_width];
    preg_t new_prd [rename_width];
    logic [slot_idx_w-1:0] need_pfx [rename_width];
    logic [grp_cnt_w-1:0] alloc_cnt;
    logic [grp_cnt_w-1:0] rollback_cnt;
    logic [free_cnt_w-1:0] free_cnt;
    logic [commit_width-1:0] commit_we;
    logic [commit_width-1:0] commit_cancel;
    logic [commit_width-1:0] arch_we;
    areg_t commit_rd [commit_width];
    preg_t commit_prd [commit_width];
    preg_t arch_rdata [commit_width];
    logic [walk_width-1:0] walk_we;
    logic [walk_width-1:0] walk_cancel;
    areg_t walk_rd [walk_width];

    // three speculative lookups per slot, then prds handed out in slot order
    for (genvar i = 0; i < rename_width; i++) begin : g_slot
        assign spec_raddr[3*i] = rename_req[i].rs1;
        assign spec_raddr[3*i+1] = rename_req[i].rs2;
        assign spec_raddr[3*i+2] = rename_req[i].rd;
        assign table_rs1[i] = spec_rdata[3*i];
        assign table_rs2[i] = spec_rdata[3*i+1];
        assign table_rd[i] = spec_rdata[3*i+2];
        if (i == 0) begin : g_first
            assign need_pfx[i] = '0;
        end else begin : g_next
            assign need_pfx[i] = need_pfx[i-1]
                + slot_idx_w'(rename_req[i-1].valid & rename_req[i-1].has_rd);
        end
        assign new_prd[i] = alloc_prd[need_pfx[i]];
    end

    for (genvar i = 0; i < commit_width; i++) begin : g_commit
        assign commit_we[i] = commit_grp[i].en & commit_grp[i].we;
        assign commit_rd[i] = commit_grp[i].rd;
        assign commit_prd[i] = commit_grp[i].prd;
        // an overwritten slot frees its own prd, the survivor frees the old mapping
        assign free_prd[i] = commit_cancel[i] ? commit_grp[i].prd : arch_rdata[i];
    end
    assign arch_we = commit_we & ~commit_cancel;

    for (genvar i = 0; i < walk_width; i++) begin : g_walk
        assign walk_we[i] = walk_grp[i].en & walk_grp[i].we;
        assign walk_rd[i] = walk_grp[i].rd;
    end

    map_table #(.n_read(spec_reads), .n_write(rename_width)) spec_rat (
        .clk(clk), .rst(rst), .raddr(spec_raddr), .rdata(spec_rdata),
        .we(spec_we), .waddr(spec_waddr), .wdata(spec_wdata)
    );

    map_table #(.n_read(commit_width), .n_write(commit_width)) arch_rat (
        .clk(clk), .rst(rst), .raddr(commit_rd), .rdata(arch_rdata),
        .we(arch_we), .waddr(commit_rd), .wdata(commit_prd)
    );

    waw_filter #(.n(commit_width)) commit_waw (
        .we(commit_we), .rd(commit_rd), .cancel(commit_cancel)
    );

    waw_filter #(.n(walk_width)) walk_waw (
        .we(walk_we), .rd(walk_rd), .cancel(walk_cancel)
    );

    src_bypass u_src_bypass (
        .req(rename_req), .table_rs1(table_rs1), .table_rs2(table_rs2),
        .table_rd(table_rd), .new_prd(new_prd), .res(rename_res)
    );

    free_list u_free_list (
        .clk(clk), .rst(rst), .alloc_cnt(alloc_cnt), .alloc_prd(alloc_prd),
        .push_en(commit_we), .push_prd(free_prd), .rollback_cnt(rollback_cnt),
        .free_cnt(free_cnt)
    );

    rename_ctrl u_rename_ctrl (
        .clk(clk), .rst(rst), .rename_req(rename_req), .walk_start(walk_start),
        .walk_done(walk_done), .walk_grp(walk_grp), .walk_cancel(walk_cancel),
        .free_cnt(free_cnt), .new_prd(new_prd), .spec_we(spec_we),
        .spec_waddr(spec_waddr), .spec_wdata(spec_wdata), .alloc_cnt(alloc_cnt),
        .rollback_cnt(rollback_cnt), .stall(stall)
    );

endmodule

`default_nettype wire

// ==== rename_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_ctrl (
    input  logic                                    clk,
    input  logic                                    rst,
    input  rename_bus_pkg::rename_slot_t            rename_req [rename_cfg_pkg::rename_width],
    input  logic                                    walk_start,
    input  logic                                    walk_done,
    input  rename_bus_pkg::walk_slot_t              walk_grp [rename_cfg_pkg::walk_width],
    input  logic [rename_cfg_pkg::walk_width-1:0]   walk_cancel,
    input  logic [rename_cfg_pkg::free_cnt_w-1:0]   free_cnt,
    input  rename_bus_pkg::preg_t                   new_prd [rename_cfg_pkg::rename_width],
    output logic [rename_cfg_pkg::rename_width-1:0] spec_we,
    output rename_bus_pkg::areg_t                   spec_waddr [rename_cfg_pkg::rename_width],
    output rename_bus_pkg::preg_t                   spec_wdata [rename_cfg_pkg::rename_width],
    output logic [rename_cfg_pkg::grp_cnt_w-1:0]    alloc_cnt,
    output logic [rename_cfg_pkg::grp_cnt_w-1:0]    rollback_cnt,
    output logic                                    stall
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    rename_state_e state_q;
    logic [grp_cnt_w-1:0] demand;
    logic [grp_cnt_w-1:0] walk_cnt;

    always_comb begin
        demand = '0;
        for (int i = 0; i < rename_width; i++) begin
            demand = demand + grp_cnt_w'(rename_req[i].valid & rename_req[i].has_rd);
        end
    end

    // every enabled walk write returns one register, cancelled or not
    always_comb begin
        walk_cnt = '0;
        for (int i = 0; i < walk_width; i++) begin
            walk_cnt = walk_cnt + grp_cnt_w'(walk_grp[i].en & walk_grp[i].we);
        end
    end

    assign stall = (state_q == st_walk) || (int'(free_cnt) < int'(demand));
    assign alloc_cnt = stall ? '0 : demand;
    assign rollback_cnt = (state_q == st_walk) ? walk_cnt : '0;

    // walk and rename share the speculative table write ports
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            if (state_q == st_walk) begin
                spec_we[i] = walk_grp[i].en & walk_grp[i].we & ~walk_cancel[i];
                spec_waddr[i] = walk_grp[i].rd;
                spec_wdata[i] = walk_grp[i].old_prd;
            end else begin
                spec_we[i] = ~stall & rename_req[i].valid & rename_req[i].has_rd;
                spec_waddr[i] = rename_req[i].rd;
                spec_wdata[i] = new_prd[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_run;
        end else begin
            case (state_q)
                st_run: if (walk_start) state_q <= st_walk;
                st_walk: if (walk_done) state_q <= st_run;
                default: state_q <= st_run;
            endcase
        end
    end

    a_walk_done_in_walk: assert property (
        @(posedge clk) disable iff (rst)
        walk_done |-> state_q == st_walk
    ) else $error("walk_done seen outside a recovery walk");

endmodule

`default_nettype wire

// ==== free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [rename_cfg_pkg::grp_cnt_w-1:0]    alloc_cnt,
    output rename_bus_pkg::preg_t                   alloc_prd [rename_cfg_pkg::rename_width],
    input  logic [rename_cfg_pkg::commit_width-1:0] push_en,
    input  rename_bus_pkg::preg_t                   push_prd [rename_cfg_pkg::commit_width],
    input  logic [rename_cfg_pkg::grp_cnt_w-1:0]    rollback_cnt,
    output logic [rename_cfg_pkg::free_cnt_w-1:0]   free_cnt
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    preg_t fifo_q [free_depth];
    logic [free_ptr_w-1:0] head_q;
    logic [free_ptr_w-1:0] tail_q;
    logic [free_ptr_w-1:0] push_ofs [commit_width];
    logic [grp_cnt_w-1:0] push_cnt;

    // next entries from the head, whether or not they get taken
    for (genvar i = 0; i < rename_width; i++) begin : g_alloc
        assign alloc_prd[i] = fifo_q[head_q + free_ptr_w'(i)];
    end

    // enabled pushes are packed together at the tail
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < commit_width; i++) begin
            push_ofs[i] = tail_q + free_ptr_w'(push_cnt);
            push_cnt = push_cnt + grp_cnt_w'(push_en[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            free_cnt <= free_cnt_w'(free_depth);
            for (int i = 0; i < free_depth; i++) begin
                fifo_q[i] <= preg_t'(arch_regs + i);
            end
        end else begin
            for (int i = 0; i < commit_width; i++) begin
                if (push_en[i]) begin
                    fifo_q[push_ofs[i]] <= push_prd[i];
                end
            end
            // rolled-back entries are still in place behind the head
            head_q <= head_q + free_ptr_w'(alloc_cnt) - free_ptr_w'(rollback_cnt);
            tail_q <= tail_q + free_ptr_w'(push_cnt);
            free_cnt <= free_cnt + free_cnt_w'(push_cnt) + free_cnt_w'(rollback_cnt)
                        - free_cnt_w'(alloc_cnt);
        end
    end

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        int'(alloc_cnt) <= int'(free_cnt)
    ) else $error("free list allocates more registers than it holds");

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        int'(free_cnt) <= free_depth
    ) else $error("free list count exceeds its depth");

endmodule

`default_nettype wire

// ==== src_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

module src_bypass (
    input  rename_bus_pkg::rename_slot_t req [rename_cfg_pkg::rename_width],
    input  rename_bus_pkg::preg_t table_rs1 [rename_cfg_pkg::rename_width],
    input  rename_bus_pkg::preg_t table_rs2 [rename_cfg_pkg::rename_width],
    input  rename_bus_pkg::preg_t table_rd [rename_cfg_pkg::rename_width],
    input  rename_bus_pkg::preg_t new_prd [rename_cfg_pkg::rename_width],
    output rename_bus_pkg::rename_res_t res [rename_cfg_pkg::rename_width]
);

    import rename_cfg_pkg::*;

    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            res[i].prs1 = table_rs1[i];
            res[i].prs2 = table_rs2[i];
            res[i].old_prd = table_rd[i];
            res[i].prd = new_prd[i];
            // walk older slots in order so the youngest matching writer wins
            for (int j = 0; j < i; j++) begin
                if (req[j].valid && req[j].has_rd) begin
                    if (req[i].rs1 == req[j].rd)
                        res[i].prs1 = new_prd[j];
                    if (req[i].rs2 == req[j].rd)
                        res[i].prs2 = new_prd[j];
                    if (req[i].rd == req[j].rd)
                        res[i].old_prd = new_prd[j];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== waw_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module waw_filter #(
    parameter int n = 2
) (
    input  logic [n-1:0]          we,
    input  rename_bus_pkg::areg_t rd [n],
    output logic [n-1:0]          cancel
);

    // a slot is cancelled when any younger slot writes the same rd
    always_comb begin
        for (int i = 0; i < n; i++) begin
            cancel[i] = 1'b0;
            for (int j = i + 1; j < n; j++) begin
                if (we[i] && we[j] && (rd[i] == rd[j])) begin
                    cancel[i] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table #(
    parameter int n_read = 1,
    parameter int n_write = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  rename_bus_pkg::areg_t raddr [n_read],
    output rename_bus_pkg::preg_t rdata [n_read],
    input  logic [n_write-1:0]    we,
    input  rename_bus_pkg::areg_t waddr [n_write],
    input  rename_bus_pkg::preg_t wdata [n_write]
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    preg_t map_q [arch_regs];

    // reads see the table as it stood at the last edge
    for (genvar r = 0; r < n_read; r++) begin : g_read
        assign rdata[r] = map_q[raddr[r]];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int a = 0; a < arch_regs; a++) begin
                map_q[a] <= preg_t'(a);
            end
        end else begin
            // later ports overwrite earlier ones on the same entry
            for (int w = 0; w < n_write; w++) begin
                if (we[w]) begin
                    map_q[waddr[w]] <= wdata[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rename_bus_pkg.sv ====
`default_nettype none

package rename_bus_pkg;

    import rename_cfg_pkg::*;

    typedef logic [areg_w-1:0] areg_t;
    typedef logic [preg_w-1:0] preg_t;

    // one instruction entering rename
    typedef struct packed {
        logic  valid;
        logic  has_rd;
        areg_t rd;
        areg_t rs1;
        areg_t rs2;
    } rename_slot_t;

    typedef struct packed {
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        preg_t old_prd;
    } rename_res_t;

    typedef struct packed {
        logic  en;
        logic  we;
        areg_t rd;
        preg_t prd;
    } commit_slot_t;

    // old_prd is the mapping restored into the speculative table
    typedef struct packed {
        logic  en;
        logic  we;
        areg_t rd;
        preg_t prd;
        preg_t old_prd;
    } walk_slot_t;

    typedef enum logic {
        st_run,
        st_walk
    } rename_state_e;

endpackage

`default_nettype wire

// ==== rename_cfg_pkg.sv ====
`default_nettype none

package rename_cfg_pkg;

    // group widths
    localparam int rename_width = 2;
    localparam int commit_width = 2;
    localparam int walk_width = 2;

    // register files
    localparam int arch_regs = 32;
    localparam int areg_w = 5;
    localparam int phys_regs = 64;
    localparam int preg_w = 6;

    // free list holds every physical register not mapped at reset
    localparam int free_depth = phys_regs - arch_regs;
    localparam int free_cnt_w = 6;
    localparam int free_ptr_w = 5;

    // per-group counts and slot indexes
    localparam int grp_cnt_w = 2;
    localparam int slot_idx_w = $clog2(rename_width);

    // rs1, rs2 and rd lookups for every rename slot
    localparam int spec_reads = 3 * rename_width;

endpackage

`default_nettype wire
